// File: src/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int DATA_WIDTH     = 32;
    localparam int BYTE_LANES     = DATA_WIDTH / 8;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OFFSET_WIDTH   = 3;

    typedef enum logic [1:0] {
        MEM_OP_NOP   = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_t;

    // ------------------------------
    // Payloads
    // ------------------------------
    typedef struct packed {
        mem_op_t                   op;
        logic [REG_ADDR_WIDTH-1:0] dest_reg_addr;
        logic [OFFSET_WIDTH-1:0]   dest_offset_addr;
        logic [DATA_WIDTH-1:0]     a;               // Store data.
        logic [DATA_WIDTH-1:0]     mem_base_addr;
        logic [DATA_WIDTH-1:0]     mem_offset_addr;
    } memory_command_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] dest_reg_addr;
        logic [OFFSET_WIDTH-1:0]   dest_offset_addr;
    } partial_result_t;

    typedef struct packed {
        logic                  read_enable;
        logic [BYTE_LANES-1:0] write_enable;
        logic [DATA_WIDTH-1:0] addr;         // Byte address.
        logic [DATA_WIDTH-1:0] data;
    } mem_request_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] dest_reg_addr;
        logic [OFFSET_WIDTH-1:0]   dest_offset_addr;
        logic [DATA_WIDTH-1:0]     data;
    } load_result_t;

endpackage

`default_nettype wire

// File: src/stream_intf.sv
`timescale 1ns/1ns
`default_nettype none

// Valid/ready stream. A transfer happens when both are high at a clock edge.
interface stream_intf #(
    parameter type T = logic
);

    logic valid;
    logic ready;
    T     payload;

    modport in (
        input  valid,
        input  payload,
        output ready
    );

    modport out (
        output valid,
        output payload,
        input  ready
    );

endinterface

`default_nettype wire

// File: src/flow_fork.sv
`timescale 1ns/1ns
`default_nettype none

module flow_fork #(
    parameter int NUM_OUTPUTS = 2
)(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   in_valid,
    output logic                   in_ready,

    output logic [NUM_OUTPUTS-1:0] out_valid,
    input  logic [NUM_OUTPUTS-1:0] out_ready,

    input  logic [NUM_OUTPUTS-1:0] produce,
    output logic                   consume
);

    logic [NUM_OUTPUTS-1:0] served;  // Outputs that took the current item.
    logic [NUM_OUTPUTS-1:0] pending;

    assign pending   = produce & ~served;
    assign out_valid = {NUM_OUTPUTS{in_valid}} & pending;

    // Done once every wanted output is either served or taking it now.
    assign in_ready = &(~pending | out_ready);
    assign consume  = in_valid & in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            served <= '0;
        end else if (consume) begin
            served <= '0;
        end else begin
            served <= served | (out_valid & out_ready);
        end
    end

endmodule

`default_nettype wire

// File: src/output_stage.sv
`timescale 1ns/1ns
`default_nettype none

module output_stage #(
    parameter type T    = logic,
    parameter int  MODE = 1
)(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  stream_in,
    stream_intf.out stream_out
);

    generate
        if (MODE == 0) begin : g_pass
            assign stream_out.valid   = stream_in.valid;
            assign stream_out.payload = stream_in.payload;
            assign stream_in.ready    = stream_out.ready;
        end else begin : g_reg
            logic main_valid;
            logic skid_valid;
            T     main_data;
            T     skid_data;
            logic in_fire;
            logic main_load;

            assign stream_in.ready    = ~skid_valid;  // Registered ready.
            assign stream_out.valid   = main_valid;
            assign stream_out.payload = main_data;

            assign in_fire   = stream_in.valid & ~skid_valid;
            assign main_load = ~main_valid | stream_out.ready;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                end else if (main_load) begin
                    main_valid <= skid_valid | in_fire;
                    skid_valid <= 1'b0;
                end else if (in_fire) begin
                    skid_valid <= 1'b1;  // Main is stalled so the item waits here.
                end
            end

            always_ff @(posedge clk) begin
                if (main_load) begin
                    main_data <= skid_valid ? skid_data : stream_in.payload;
                end else if (in_fire) begin
                    skid_data <= stream_in.payload;
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/memory_command_unit.sv
`timescale 1ns/1ns
`default_nettype none

module memory_command_unit #(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  memory_command,        // memory_command_t
    stream_intf.out memory_request,        // mem_request_t
    stream_intf.out partial_memory_result  // partial_result_t
);

    stream_intf #(.T(mem_stage_pkg::mem_request_t))    next_request ();
    stream_intf #(.T(mem_stage_pkg::partial_result_t)) next_partial ();

    mem_stage_pkg::mem_request_t    request;
    mem_stage_pkg::partial_result_t partial;

    logic       is_load;
    logic [1:0] fork_valid;
    logic [1:0] fork_ready;

    // ------------------------------
    // Fork into request and partial
    // ------------------------------
    flow_fork #(
        .NUM_OUTPUTS(2)
    ) flow_fork_inst (
        .clk,
        .rst_n,
        .in_valid  (memory_command.valid),
        .in_ready  (memory_command.ready),
        .out_valid (fork_valid),
        .out_ready (fork_ready),
        .produce   ({1'b1, is_load}),  // Every command makes a request.
        .consume   ()
    );

    assign next_request.valid   = fork_valid[1];
    assign next_partial.valid   = fork_valid[0];
    assign fork_ready           = {next_request.ready, next_partial.ready};
    assign next_request.payload = request;
    assign next_partial.payload = partial;

    output_stage #(
        .T    (mem_stage_pkg::mem_request_t),
        .MODE (OUTPUT_REGISTER_MODE)
    ) request_stage_inst (
        .clk,
        .rst_n,
        .stream_in  (next_request),
        .stream_out (memory_request)
    );

    output_stage #(
        .T    (mem_stage_pkg::partial_result_t),
        .MODE (OUTPUT_REGISTER_MODE)
    ) partial_stage_inst (
        .clk,
        .rst_n,
        .stream_in  (next_partial),
        .stream_out (partial_memory_result)
    );

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        is_load                  = 1'b0;
        partial.dest_reg_addr    = memory_command.payload.dest_reg_addr;
        partial.dest_offset_addr = memory_command.payload.dest_offset_addr;

        request.read_enable  = 1'b0;
        request.write_enable = '0;
        request.data         = memory_command.payload.a;
        request.addr         = memory_command.payload.mem_base_addr
                             + memory_command.payload.mem_offset_addr;

        case (memory_command.payload.op)
            mem_stage_pkg::MEM_OP_LOAD: begin
                is_load             = 1'b1;
                request.read_enable = 1'b1;
            end
            mem_stage_pkg::MEM_OP_STORE: begin
                request.write_enable = '1;  // Full word.
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

module data_memory #(
    parameter int MEM_ADDR_WIDTH = 6
)(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  request,  // mem_request_t
    stream_intf.out response  // Read data word.
);

    localparam int NUM_WORDS = 2 ** MEM_ADDR_WIDTH;
    localparam int DW        = mem_stage_pkg::DATA_WIDTH;

    logic [DW-1:0]             words [NUM_WORDS];
    logic [DW-1:0]             response_data;
    logic                      response_valid;
    logic [MEM_ADDR_WIDTH-1:0] word_index;
    logic                      request_fire;
    logic                      read_fire;

    // Upper address bits wrap.
    assign word_index = request.payload.addr[MEM_ADDR_WIDTH+1:2];

    // Accept while the response register is empty or draining.
    assign request.ready = ~response_valid | response.ready;
    assign request_fire  = request.valid & request.ready;
    assign read_fire     = request_fire & request.payload.read_enable;

    assign response.valid   = response_valid;
    assign response.payload = response_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            response_valid <= 1'b0;
        end else if (read_fire) begin
            response_valid <= 1'b1;
        end else if (response.ready) begin
            response_valid <= 1'b0;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (read_fire) begin
            response_data <= words[word_index];
        end
        if (request_fire) begin
            for (int lane = 0; lane < mem_stage_pkg::BYTE_LANES; lane++) begin
                if (request.payload.write_enable[lane]) begin
                    words[word_index][lane*8 +: 8] <= request.payload.data[lane*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/load_result_join.sv
`timescale 1ns/1ns
`default_nettype none

module load_result_join #(
    parameter int PENDING_DEPTH = 4
)(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  partial,   // partial_result_t
    stream_intf.in  response,  // Read data word.
    stream_intf.out result     // load_result_t
);

    localparam int PTR_WIDTH   = (PENDING_DEPTH > 1) ? $clog2(PENDING_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(PENDING_DEPTH + 1);

    mem_stage_pkg::partial_result_t entries [PENDING_DEPTH];
    mem_stage_pkg::partial_result_t head;

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   not_empty;
    logic                   push;
    logic                   pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(PENDING_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty     = (count != '0);
    assign partial.ready = (count != COUNT_WIDTH'(PENDING_DEPTH));
    assign push          = partial.valid & partial.ready;

    // ------------------------------
    // Join
    // ------------------------------
    assign head           = entries[rd_ptr];
    assign result.valid   = not_empty & response.valid;
    assign response.ready = not_empty & result.ready;
    assign pop            = result.valid & result.ready;

    assign result.payload = '{
        dest_reg_addr:    head.dest_reg_addr,
        dest_offset_addr: head.dest_offset_addr,
        data:             response.payload
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= partial.payload;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top #(
    parameter int OUTPUT_REGISTER_MODE = 1,
    parameter int MEM_ADDR_WIDTH       = 6,
    parameter int PENDING_DEPTH        = 4
)(
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic                                    cmd_valid,
    output logic                                    cmd_ready,
    input  mem_stage_pkg::mem_op_t                  cmd_op,
    input  logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] cmd_dest_reg_addr,
    input  logic [mem_stage_pkg::OFFSET_WIDTH-1:0]  cmd_dest_offset_addr,
    input  logic [mem_stage_pkg::DATA_WIDTH-1:0]    cmd_data,
    input  logic [mem_stage_pkg::DATA_WIDTH-1:0]    cmd_base_addr,
    input  logic [mem_stage_pkg::DATA_WIDTH-1:0]    cmd_offset_addr,

    output logic                                    result_valid,
    input  logic                                    result_ready,
    output logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] result_dest_reg_addr,
    output logic [mem_stage_pkg::OFFSET_WIDTH-1:0]  result_dest_offset_addr,
    output logic [mem_stage_pkg::DATA_WIDTH-1:0]    result_data
);

    stream_intf #(.T(mem_stage_pkg::memory_command_t))        command_stream ();
    stream_intf #(.T(mem_stage_pkg::mem_request_t))           request_stream ();
    stream_intf #(.T(mem_stage_pkg::partial_result_t))        partial_stream ();
    stream_intf #(.T(logic [mem_stage_pkg::DATA_WIDTH-1:0]))  response_stream ();
    stream_intf #(.T(mem_stage_pkg::load_result_t))           result_stream ();

    // ------------------------------
    // Port packing
    // ------------------------------
    assign command_stream.valid   = cmd_valid;
    assign cmd_ready              = command_stream.ready;
    assign command_stream.payload = '{
        op:               cmd_op,
        dest_reg_addr:    cmd_dest_reg_addr,
        dest_offset_addr: cmd_dest_offset_addr,
        a:                cmd_data,
        mem_base_addr:    cmd_base_addr,
        mem_offset_addr:  cmd_offset_addr
    };

    assign result_valid            = result_stream.valid;
    assign result_stream.ready     = result_ready;
    assign result_dest_reg_addr    = result_stream.payload.dest_reg_addr;
    assign result_dest_offset_addr = result_stream.payload.dest_offset_addr;
    assign result_data             = result_stream.payload.data;

    memory_command_unit #(
        .OUTPUT_REGISTER_MODE(OUTPUT_REGISTER_MODE)
    ) memory_command_unit_inst (
        .clk,
        .rst_n,
        .memory_command        (command_stream),
        .memory_request        (request_stream),
        .partial_memory_result (partial_stream)
    );

    data_memory #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) data_memory_inst (
        .clk,
        .rst_n,
        .request  (request_stream),
        .response (response_stream)
    );

    load_result_join #(
        .PENDING_DEPTH(PENDING_DEPTH)
    ) load_result_join_inst (
        .clk,
        .rst_n,
        .partial  (partial_stream),
        .response (response_stream),
        .result   (result_stream)
    );

endmodule

`default_nettype wire

// File: tb/mem_stage_assert.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_assert (
    input logic                                     clk,
    input logic                                     rst_n,
    input logic                                     cmd_valid,
    input logic                                     cmd_ready,
    input mem_stage_pkg::mem_op_t                   cmd_op,
    input logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] cmd_dest_reg_addr,
    input logic [mem_stage_pkg::OFFSET_WIDTH-1:0]   cmd_dest_offset_addr,
    input logic [mem_stage_pkg::DATA_WIDTH-1:0]     cmd_data,
    input logic [mem_stage_pkg::DATA_WIDTH-1:0]     cmd_base_addr,
    input logic [mem_stage_pkg::DATA_WIDTH-1:0]     cmd_offset_addr,
    input logic                                     result_valid,
    input logic                                     result_ready,
    input logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] result_dest_reg_addr,
    input logic [mem_stage_pkg::OFFSET_WIDTH-1:0]   result_dest_offset_addr,
    input logic [mem_stage_pkg::DATA_WIDTH-1:0]     result_data
);

    int   failures;
    logic load_seen;  // A load command has transferred since reset.

    initial failures = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_seen <= 1'b0;
        end else if (cmd_valid && cmd_ready && cmd_op == mem_stage_pkg::MEM_OP_LOAD) begin
            load_seen <= 1'b1;
        end
    end

    // ------------------------------
    // Reset and idle
    // ------------------------------
    result_low_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
    else begin
        failures++;
        $error("result_valid high during reset");
    end

    result_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !result_valid)
    else begin
        failures++;
        $error("result_valid high in the cycle after reset");
    end

    result_low_before_load: assert property (
        @(posedge clk) disable iff (!rst_n) !load_seen |-> !result_valid
    ) else begin
        failures++;
        $error("result_valid high before any load was issued");
    end

    cmd_ready_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(cmd_ready))
    else begin
        failures++;
        $error("cmd_ready is unknown");
    end

    // ------------------------------
    // Stream stability
    // ------------------------------
    cmd_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_dest_reg_addr)
            && $stable(cmd_dest_offset_addr) && $stable(cmd_data)
            && $stable(cmd_base_addr) && $stable(cmd_offset_addr)
    ) else begin
        failures++;
        $error("command changed while stalled");
    end

    result_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result_dest_reg_addr)
            && $stable(result_dest_offset_addr) && $stable(result_data)
    ) else begin
        failures++;
        $error("result changed while stalled");
    end

endmodule

bind mem_stage_top mem_stage_assert mem_stage_assert_inst (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .cmd_valid               (cmd_valid),
    .cmd_ready               (cmd_ready),
    .cmd_op                  (cmd_op),
    .cmd_dest_reg_addr       (cmd_dest_reg_addr),
    .cmd_dest_offset_addr    (cmd_dest_offset_addr),
    .cmd_data                (cmd_data),
    .cmd_base_addr           (cmd_base_addr),
    .cmd_offset_addr         (cmd_offset_addr),
    .result_valid            (result_valid),
    .result_ready            (result_ready),
    .result_dest_reg_addr    (result_dest_reg_addr),
    .result_dest_offset_addr (result_dest_offset_addr),
    .result_data             (result_data)
);

`default_nettype wire

// File: tb/mem_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb;

    localparam int OUTPUT_REGISTER_MODE = 1;
    localparam int MEM_ADDR_WIDTH       = 6;
    localparam int PENDING_DEPTH        = 4;
    localparam int NUM_WORDS            = 2 ** MEM_ADDR_WIDTH;
    localparam int LOAD_LATENCY         = (OUTPUT_REGISTER_MODE == 1) ? 2 : 1;
    localparam int WAIT_LIMIT           = 200;
    localparam int NUM_RANDOM           = 400;

    typedef struct packed {
        logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] dest_reg_addr;
        logic [mem_stage_pkg::OFFSET_WIDTH-1:0]   dest_offset_addr;
        logic [31:0]                              data;
        logic                                     timed;  // Latency is checked.
        logic [31:0]                              accept_cycle;
    } expected_t;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     cmd_valid;
    logic                                     cmd_ready;
    mem_stage_pkg::mem_op_t                   cmd_op;
    logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] cmd_dest_reg_addr;
    logic [mem_stage_pkg::OFFSET_WIDTH-1:0]   cmd_dest_offset_addr;
    logic [31:0]                              cmd_data;
    logic [31:0]                              cmd_base_addr;
    logic [31:0]                              cmd_offset_addr;
    logic                                     result_valid;
    logic                                     result_ready;
    logic [mem_stage_pkg::REG_ADDR_WIDTH-1:0] result_dest_reg_addr;
    logic [mem_stage_pkg::OFFSET_WIDTH-1:0]   result_dest_offset_addr;
    logic [31:0]                              result_data;

    logic [31:0] ref_mem [NUM_WORDS];
    expected_t   expected_q [$];
    expected_t   head_entry;
    logic [31:0] cycle;
    logic [31:0] cmd_state;
    logic [31:0] ready_state;
    logic        timing_on;
    logic        random_ready;
    int          check_errors;
    int          timeout_errors;
    int          assertion_failures;
    int          load_count;
    int          result_count;

    mem_stage_top #(
        .OUTPUT_REGISTER_MODE (OUTPUT_REGISTER_MODE),
        .MEM_ADDR_WIDTH       (MEM_ADDR_WIDTH),
        .PENDING_DEPTH        (PENDING_DEPTH)
    ) mem_stage_top_inst (
        .clk, .rst_n,
        .cmd_valid, .cmd_ready, .cmd_op, .cmd_dest_reg_addr, .cmd_dest_offset_addr,
        .cmd_data, .cmd_base_addr, .cmd_offset_addr,
        .result_valid, .result_ready, .result_dest_reg_addr, .result_dest_offset_addr,
        .result_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial cycle = '0;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        cmd_state = xorshift32(cmd_state);
        return cmd_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] index);
        return {8'hA5, index[7:0], ~index[7:0], index[7:0] ^ 8'h3C};
    endfunction

    // ------------------------------
    // Command driver
    // ------------------------------
    task automatic send_command(input mem_stage_pkg::mem_op_t op,
                                input logic [4:0] reg_addr, input logic [2:0] offset_addr,
                                input logic [31:0] data, input logic [31:0] base,
                                input logic [31:0] offset);
        int                        waited;
        logic                      accepted;
        logic [31:0]               addr_sum;
        logic [MEM_ADDR_WIDTH-1:0] index;
        expected_t                 entry;
        cmd_valid            = 1'b1;
        cmd_op               = op;
        cmd_dest_reg_addr    = reg_addr;
        cmd_dest_offset_addr = offset_addr;
        cmd_data             = data;
        cmd_base_addr        = base;
        cmd_offset_addr      = offset;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(negedge clk);
            accepted           = cmd_ready;  // Transfer happens on the next edge.
            entry.accept_cycle = cycle;
            @(posedge clk);
            waited++;
        end
        if (!accepted) begin
            $display("Timeout: a command was not accepted within %0d cycles", WAIT_LIMIT);
            timeout_errors++;
        end else begin
            addr_sum = base + offset;
            index    = MEM_ADDR_WIDTH'((addr_sum >> 2) % NUM_WORDS);  // Word index wraps in the memory.
            if (op == mem_stage_pkg::MEM_OP_STORE) begin
                ref_mem[index] = data;
            end else if (op == mem_stage_pkg::MEM_OP_LOAD) begin
                entry.dest_reg_addr    = reg_addr;
                entry.dest_offset_addr = offset_addr;
                entry.data             = ref_mem[index];
                entry.timed            = timing_on;
                expected_q.push_back(entry);
                load_count++;
            end
        end
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_for_results();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout: %0d loads still had no result", expected_q.size());
            timeout_errors++;
        end
        @(posedge clk);
        #2;
    endtask

    // Result_ready gaps come from a random stream of their own.
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (random_ready) begin
                ready_state  = xorshift32(ready_state);
                result_ready = (ready_state[2:0] < 3'd3);
            end else begin
                result_ready = 1'b1;
            end
        end
    end

    // ------------------------------
    // Scoreboard
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n && result_valid && result_ready) begin
            result_count++;
            if (expected_q.size() == 0) begin
                $display("A result appeared while no load was waiting for one");
                check_errors++;
            end else begin
                head_entry = expected_q.pop_front();
                assert (result_data == head_entry.data) else begin
                    $display("CHECK FAILED result_data: got %h, expected %h",
                             result_data, head_entry.data);
                    check_errors++;
                end
                assert (result_dest_reg_addr == head_entry.dest_reg_addr) else begin
                    $display("CHECK FAILED result_dest_reg_addr: got %h, expected %h",
                             result_dest_reg_addr, head_entry.dest_reg_addr);
                    check_errors++;
                end
                assert (result_dest_offset_addr == head_entry.dest_offset_addr) else begin
                    $display("CHECK FAILED result_dest_offset_addr: got %h, expected %h",
                             result_dest_offset_addr, head_entry.dest_offset_addr);
                    check_errors++;
                end
                if (head_entry.timed) begin
                    assert (cycle - head_entry.accept_cycle == LOAD_LATENCY) else begin
                        $display("CHECK FAILED result latency: got %h, expected %h",
                                 cycle - head_entry.accept_cycle, LOAD_LATENCY);
                        check_errors++;
                    end
                end
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        int                     i;
        logic [31:0]            pick;
        mem_stage_pkg::mem_op_t op;
        rst_n                = 1'b0;
        cmd_valid            = 1'b0;
        cmd_op               = mem_stage_pkg::MEM_OP_NOP;
        cmd_dest_reg_addr    = '0;
        cmd_dest_offset_addr = '0;
        cmd_data             = '0;
        cmd_base_addr        = '0;
        cmd_offset_addr      = '0;
        result_ready         = 1'b1;
        timing_on            = 1'b1;
        random_ready         = 1'b0;
        cmd_state            = 32'd19;
        ready_state          = xorshift32(32'd19 ^ 32'h5A5A_5A5A);
        check_errors         = 0;
        timeout_errors       = 0;
        load_count           = 0;
        result_count         = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Result_valid has to stay low while no load has been issued.
        send_command(mem_stage_pkg::MEM_OP_NOP, 5'd1, 3'd1, 32'h1111_1111, 32'h0, 32'h8);
        send_command(mem_stage_pkg::MEM_OP_STORE, 5'd2, 3'd2, 32'h2222_2222, 32'h0, 32'h8);
        repeat (6) @(posedge clk);
        #2;

        for (i = 0; i < NUM_WORDS; i++) begin
            send_command(mem_stage_pkg::MEM_OP_STORE, 5'd0, 3'd0, fill_word(i), i * 4, 32'h0);
        end

        // Store and load back followed by aliased base and offset pairs.
        send_command(mem_stage_pkg::MEM_OP_STORE, 5'd3, 3'd0, 32'hDEAD_BEEF, 32'h40, 32'h0);
        send_command(mem_stage_pkg::MEM_OP_LOAD, 5'd7, 3'd3, 32'h0, 32'h40, 32'h0);
        send_command(mem_stage_pkg::MEM_OP_STORE, 5'd4, 3'd0, 32'h1234_5678, 32'h10, 32'h4);
        send_command(mem_stage_pkg::MEM_OP_LOAD, 5'd9, 3'd1, 32'h0, 32'h1000, 32'hFFFF_F114);
        send_command(mem_stage_pkg::MEM_OP_LOAD, 5'd10, 3'd2, 32'h0, 32'hFFFF_FF00, 32'h14);
        send_command(mem_stage_pkg::MEM_OP_NOP, 5'd11, 3'd4, 32'h0, 32'h14, 32'h0);
        send_command(mem_stage_pkg::MEM_OP_LOAD, 5'd12, 3'd5, 32'h0, 32'h3, 32'h11);
        wait_for_results();

        // Random traffic under result_ready back-pressure.
        timing_on    = 1'b0;
        random_ready = 1'b1;
        for (i = 0; i < NUM_RANDOM; i++) begin
            pick = next_random();
            case (pick[1:0])
                2'd0:    op = mem_stage_pkg::MEM_OP_NOP;
                2'd3:    op = mem_stage_pkg::MEM_OP_STORE;
                default: op = mem_stage_pkg::MEM_OP_LOAD;
            endcase
            send_command(op, pick[8:4], pick[11:9], next_random(), next_random(),
                         next_random());
        end
        wait_for_results();

        assert (result_count == load_count) else begin
            $display("CHECK FAILED result count: got %h, expected %h", result_count, load_count);
            check_errors++;
        end

        assertion_failures = mem_stage_top_inst.mem_stage_assert_inst.failures;
        $display("Errors: %0d check, %0d timeout, %0d assertion (%0d loads, %0d results)",
                 check_errors, timeout_errors, assertion_failures, load_count, result_count);
        if (check_errors == 0 && timeout_errors == 0 && assertion_failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/mem_stage_pkg.sv
src/stream_intf.sv
src/flow_fork.sv
src/output_stage.sv
src/memory_command_unit.sv
src/data_memory.sv
src/load_result_join.sv
src/mem_stage_top.sv
tb/mem_stage_assert.sv
tb/mem_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mem_stage_tb \
    -f verilog.f --Mdir obj_dir -o mem_stage_sim &&
./obj_dir/mem_stage_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -qx '\*\* PASS \*\*' &&
echo "Simulation passed." ||
{ echo "Simulation failed."; exit 1; }
